/* rtl/spi_bus_pkg.sv */
package spi_bus_pkg;

  // APB address and data words
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;

  // Offset inside the SPI register window
  typedef logic [4:0] reg_offset_t;

  // Register map of the SPI master
  // RX holds the low word of the shift data
  localparam reg_offset_t OFF_RX      = 5'h00;
  // TX loads the upper word of the shift data
  localparam reg_offset_t OFF_TX      = 5'h04;
  localparam reg_offset_t OFF_CTRL    = 5'h10;
  localparam reg_offset_t OFF_DIVIDER = 5'h14;
  localparam reg_offset_t OFF_SS      = 5'h18;

  // What a decoded APB access turns into
  typedef enum logic [1:0] {
    REQ_REG,
    REQ_FLASH,
    REQ_BAD
  } req_kind_e;

  // Flash window, read only
  localparam bus_addr_t FLASH_BASE_DEF = 32'h3000_0000;
  localparam bus_addr_t FLASH_END_DEF  = 32'h3FFF_FFFF;

  // Direct register window
  localparam bus_addr_t REG_BASE_DEF   = 32'h1000_1000;
  localparam bus_addr_t REG_END_DEF    = 32'h1000_1FFF;

endpackage

/* rtl/spi_core_pkg.sv */
package spi_core_pkg;

  // Bits per transfer, 0 stands for 64
  typedef logic [6:0] char_len_t;

  // CTRL field positions
  localparam int CTRL_LEN_MSB = 6;
  localparam int CTRL_LEN_LSB = 0;
  localparam int CTRL_GO_BIT  = 8;
  localparam int CTRL_IE_BIT  = 12;

  // Serial NOR read, one command byte then 24 address bits
  localparam logic [7:0]  FLASH_READ_CMD = 8'h03;
  // Divider used for flash reads, sck at clock/4
  localparam logic [31:0] XIP_DIVIDER    = 32'd1;

  typedef enum logic [2:0] {
    XIP_IDLE, XIP_LOAD_TX, XIP_SET_DIV, XIP_SET_SS,
    XIP_START, XIP_POLL, XIP_READ_RX, XIP_RESPOND
  } xip_state_e;

  typedef enum logic {SH_IDLE, SH_SHIFT} shift_state_e;

endpackage

/* rtl/spi_reg_if.sv */
`timescale 1ns/1ps

interface spi_reg_if;

  // Request side, held stable until ack
  logic                   stb;
  spi_bus_pkg::req_kind_e kind;
  spi_bus_pkg::bus_addr_t addr;
  spi_bus_pkg::bus_data_t wdata;
  logic                   we;

  // Response side, valid with ack
  logic                   ack;
  spi_bus_pkg::bus_data_t rdata;
  logic                   err;

  modport master (
    output stb, kind, addr, wdata, we,
    input  ack, rdata, err
  );

  modport slave (
    input  stb, kind, addr, wdata, we,
    output ack, rdata, err
  );

endinterface

/* rtl/apb_window_decode.sv */
`timescale 1ns/1ps

module apb_window_decode #(
  parameter spi_bus_pkg::bus_addr_t flash_base = spi_bus_pkg::FLASH_BASE_DEF,
  parameter spi_bus_pkg::bus_addr_t flash_end  = spi_bus_pkg::FLASH_END_DEF,
  parameter spi_bus_pkg::bus_addr_t reg_base   = spi_bus_pkg::REG_BASE_DEF,
  parameter spi_bus_pkg::bus_addr_t reg_end    = spi_bus_pkg::REG_END_DEF
) (
  input  logic                   clock,
  input  logic                   reset,
  input  spi_bus_pkg::bus_addr_t paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  spi_bus_pkg::bus_data_t pwdata_i,
  output logic                   pready_o,
  output spi_bus_pkg::bus_data_t prdata_o,
  output logic                   pslverr_o,
  spi_reg_if.master              req_o
);

  logic                   in_flash;
  logic                   in_reg;
  logic                   access;
  logic                   waiting;
  logic [1:0]             bad_dly;
  logic                   done;
  spi_bus_pkg::req_kind_e acc_kind;

  // Window compare, flash is read only
  always_comb begin
    in_flash = (paddr_i >= flash_base) && (paddr_i <= flash_end);
    in_reg   = (paddr_i >= reg_base) && (paddr_i <= reg_end);
    if (in_reg)
      acc_kind = spi_bus_pkg::REQ_REG;
    else if (in_flash && !pwrite_i)
      acc_kind = spi_bus_pkg::REQ_FLASH;
    else
      acc_kind = spi_bus_pkg::REQ_BAD;
  end

  // First access-phase cycle only
  assign access = psel_i & penable_i & ~waiting;
  // Completion from the sequencer or the local error path
  assign done = req_o.ack | bad_dly[1];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      waiting   <= 1'b0;
      req_o.stb <= 1'b0;
      bad_dly   <= '0;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      req_o.stb <= access && (acc_kind != spi_bus_pkg::REQ_BAD);
      // Bad accesses never leave this stage
      bad_dly   <= {bad_dly[0], access && (acc_kind == spi_bus_pkg::REQ_BAD)};
      // Drop waiting once the pready cycle has been seen
      if (access)
        waiting <= 1'b1;
      else if (pready_o)
        waiting <= 1'b0;
      pready_o  <= done;
      pslverr_o <= done & (bad_dly[1] | req_o.err);
    end
  end

  // Request fields latched once per access
  always_ff @(posedge clock) begin
    if (access) begin
      req_o.kind  <= acc_kind;
      req_o.addr  <= paddr_i;
      req_o.wdata <= pwdata_i;
      req_o.we    <= pwrite_i;
    end
    if (done)
      prdata_o <= bad_dly[1] ? '0 : req_o.rdata;
  end

endmodule

/* rtl/xip_read_seq.sv */
`timescale 1ns/1ps

module xip_read_seq (
  input  logic      clock,
  input  logic      reset,
  spi_reg_if.slave  req_i,
  spi_reg_if.master reg_o
);

  spi_core_pkg::xip_state_e  state;
  spi_core_pkg::xip_state_e  state_nx;
  logic                      issue;
  spi_bus_pkg::reg_offset_t  cmd_off;
  logic                      cmd_we;
  spi_bus_pkg::bus_data_t    cmd_data;
  spi_bus_pkg::bus_data_t    rx_word;

  // Next state, a new stb goes out on every step
  always_comb begin
    state_nx = state;
    issue    = 1'b0;
    case (state)
      spi_core_pkg::XIP_IDLE: begin
        if (req_i.stb) begin
          issue = 1'b1;
          // Register requests stay in IDLE
          if (req_i.kind == spi_bus_pkg::REQ_FLASH)
            state_nx = spi_core_pkg::XIP_LOAD_TX;
        end
      end
      spi_core_pkg::XIP_LOAD_TX: begin
        if (reg_o.ack) begin
          state_nx = spi_core_pkg::XIP_SET_DIV;
          issue    = 1'b1;
        end
      end
      spi_core_pkg::XIP_SET_DIV: begin
        if (reg_o.ack) begin
          state_nx = spi_core_pkg::XIP_SET_SS;
          issue    = 1'b1;
        end
      end
      spi_core_pkg::XIP_SET_SS: begin
        if (reg_o.ack) begin
          state_nx = spi_core_pkg::XIP_START;
          issue    = 1'b1;
        end
      end
      spi_core_pkg::XIP_START: begin
        if (reg_o.ack) begin
          state_nx = spi_core_pkg::XIP_POLL;
          issue    = 1'b1;
        end
      end
      spi_core_pkg::XIP_POLL: begin
        // Read CTRL again while the shifter is busy
        if (reg_o.ack) begin
          issue = 1'b1;
          if (!reg_o.rdata[spi_core_pkg::CTRL_GO_BIT])
            state_nx = spi_core_pkg::XIP_READ_RX;
        end
      end
      spi_core_pkg::XIP_READ_RX: begin
        if (reg_o.ack) begin
          state_nx = spi_core_pkg::XIP_RESPOND;
          issue    = 1'b1;
        end
      end
      spi_core_pkg::XIP_RESPOND: begin
        if (reg_o.ack)
          state_nx = spi_core_pkg::XIP_IDLE;
      end
      default: state_nx = spi_core_pkg::XIP_IDLE;
    endcase
  end

  // Command for the state being entered
  always_comb begin
    cmd_off  = req_i.addr[4:0];
    cmd_we   = req_i.we;
    cmd_data = req_i.wdata;
    case (state_nx)
      spi_core_pkg::XIP_LOAD_TX: begin
        cmd_off  = spi_bus_pkg::OFF_TX;
        cmd_we   = 1'b1;
        cmd_data = {spi_core_pkg::FLASH_READ_CMD, req_i.addr[23:0]};
      end
      spi_core_pkg::XIP_SET_DIV: begin
        cmd_off  = spi_bus_pkg::OFF_DIVIDER;
        cmd_we   = 1'b1;
        cmd_data = spi_core_pkg::XIP_DIVIDER;
      end
      spi_core_pkg::XIP_SET_SS: begin
        cmd_off  = spi_bus_pkg::OFF_SS;
        cmd_we   = 1'b1;
        cmd_data = 32'd1;
      end
      spi_core_pkg::XIP_START: begin
        cmd_off  = spi_bus_pkg::OFF_CTRL;
        cmd_we   = 1'b1;
        cmd_data = '0;
        // Length field left at 0, a full 64-bit frame
        cmd_data[spi_core_pkg::CTRL_GO_BIT] = 1'b1;
      end
      spi_core_pkg::XIP_POLL: begin
        cmd_off  = spi_bus_pkg::OFF_CTRL;
        cmd_we   = 1'b0;
      end
      spi_core_pkg::XIP_READ_RX: begin
        cmd_off  = spi_bus_pkg::OFF_RX;
        cmd_we   = 1'b0;
      end
      spi_core_pkg::XIP_RESPOND: begin
        // Release the slave select
        cmd_off  = spi_bus_pkg::OFF_SS;
        cmd_we   = 1'b1;
        cmd_data = '0;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= spi_core_pkg::XIP_IDLE;
      reg_o.stb <= 1'b0;
    end else begin
      state     <= state_nx;
      reg_o.stb <= issue;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      reg_o.addr  <= spi_bus_pkg::bus_addr_t'(cmd_off);
      reg_o.we    <= cmd_we;
      reg_o.wdata <= cmd_data;
    end
    // Flash word kept until the SS release finishes
    if (state == spi_core_pkg::XIP_READ_RX && reg_o.ack)
      rx_word <= reg_o.rdata;
  end

  assign reg_o.kind = spi_bus_pkg::REQ_REG;

  // In IDLE any ack belongs to a forwarded register access
  assign req_i.ack   = (state == spi_core_pkg::XIP_IDLE) ? reg_o.ack :
                       (state == spi_core_pkg::XIP_RESPOND) & reg_o.ack;
  assign req_i.rdata = (state == spi_core_pkg::XIP_IDLE) ? reg_o.rdata : rx_word;
  assign req_i.err   = (state == spi_core_pkg::XIP_IDLE) & reg_o.err;

endmodule

/* rtl/spi_shift_regs.sv */
`timescale 1ns/1ps

module spi_shift_regs #(
  parameter int ss_num = 8
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              miso_i,
  spi_reg_if.slave          bus_i,
  output logic              sck_o,
  output logic [ss_num-1:0] ss_o,
  output logic              mosi_o,
  output logic              irq_o
);

  spi_core_pkg::shift_state_e sh_state;
  spi_bus_pkg::reg_offset_t   off;
  logic                       wr;
  logic                       ctrl_wr;
  logic                       tick;
  logic                       last_bit;
  logic [63:0]                shift_q;
  logic                       miso_q;
  spi_bus_pkg::bus_data_t     divider_q;
  spi_bus_pkg::bus_data_t     clk_cnt;
  spi_bus_pkg::bus_data_t     ctrl_word;
  spi_bus_pkg::bus_data_t     rd_word;
  logic                       rd_err;
  logic [ss_num-1:0]          ss_q;
  spi_core_pkg::char_len_t    char_len_q;
  spi_core_pkg::char_len_t    eff_len;
  spi_core_pkg::char_len_t    bit_cnt;
  logic                       ie_q;
  logic                       go_busy_q;
  logic                       irq_q;
  logic                       sck_q;

  assign off     = bus_i.addr[4:0];
  assign wr      = bus_i.stb & bus_i.we;
  assign ctrl_wr = wr && (off == spi_bus_pkg::OFF_CTRL);
  // One sck half period elapsed
  assign tick     = (sh_state == spi_core_pkg::SH_SHIFT) && (clk_cnt == divider_q);
  assign eff_len  = (char_len_q == '0) ? 7'd64 : char_len_q;
  assign last_bit = (bit_cnt == eff_len - 7'd1);

  always_comb begin
    ctrl_word = '0;
    ctrl_word[spi_core_pkg::CTRL_LEN_MSB:spi_core_pkg::CTRL_LEN_LSB] = char_len_q;
    ctrl_word[spi_core_pkg::CTRL_GO_BIT] = go_busy_q;
    ctrl_word[spi_core_pkg::CTRL_IE_BIT] = ie_q;
  end

  // Read mux, unmapped offsets flag an error
  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    case (off)
      spi_bus_pkg::OFF_RX:      rd_word = shift_q[31:0];
      spi_bus_pkg::OFF_TX:      rd_word = shift_q[63:32];
      spi_bus_pkg::OFF_CTRL:    rd_word = ctrl_word;
      spi_bus_pkg::OFF_DIVIDER: rd_word = divider_q;
      spi_bus_pkg::OFF_SS:      rd_word = spi_bus_pkg::bus_data_t'(ss_q);
      default:                  rd_err  = 1'b1;
    endcase
  end

  // Fixed one-cycle response
  always_ff @(posedge clock or posedge reset) begin
    if (reset)
      bus_i.ack <= 1'b0;
    else
      bus_i.ack <= bus_i.stb;
  end

  always_ff @(posedge clock) begin
    if (bus_i.stb) begin
      bus_i.rdata <= rd_word;
      bus_i.err   <= rd_err;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sh_state   <= spi_core_pkg::SH_IDLE;
      divider_q  <= '0;
      ss_q       <= '0;
      char_len_q <= '0;
      ie_q       <= 1'b0;
      go_busy_q  <= 1'b0;
      irq_q      <= 1'b0;
      sck_q      <= 1'b0;
      clk_cnt    <= '0;
      bit_cnt    <= '0;
    end else begin
      if (wr && off == spi_bus_pkg::OFF_DIVIDER)
        divider_q <= bus_i.wdata;
      if (wr && off == spi_bus_pkg::OFF_SS)
        ss_q <= bus_i.wdata[ss_num-1:0];
      if (ctrl_wr) begin
        char_len_q <= bus_i.wdata[spi_core_pkg::CTRL_LEN_MSB:spi_core_pkg::CTRL_LEN_LSB];
        ie_q       <= bus_i.wdata[spi_core_pkg::CTRL_IE_BIT];
        irq_q      <= 1'b0;
      end
      case (sh_state)
        spi_core_pkg::SH_IDLE: begin
          if (ctrl_wr && bus_i.wdata[spi_core_pkg::CTRL_GO_BIT]) begin
            sh_state  <= spi_core_pkg::SH_SHIFT;
            go_busy_q <= 1'b1;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
          end
        end
        spi_core_pkg::SH_SHIFT: begin
          if (tick) begin
            clk_cnt <= '0;
            sck_q   <= ~sck_q;
            // Falling edge closes one bit
            if (sck_q) begin
              if (last_bit) begin
                sh_state  <= spi_core_pkg::SH_IDLE;
                go_busy_q <= 1'b0;
                if (ie_q)
                  irq_q <= 1'b1;
              end else begin
                bit_cnt <= bit_cnt + 7'd1;
              end
            end
          end else begin
            clk_cnt <= clk_cnt + 32'd1;
          end
        end
        default: sh_state <= spi_core_pkg::SH_IDLE;
      endcase
    end
  end

  // Shared TX/RX shift data, MSB out, LSB in
  always_ff @(posedge clock) begin
    if (wr && off == spi_bus_pkg::OFF_TX) begin
      shift_q <= {bus_i.wdata, 32'h0};
    end else if (tick) begin
      // Sample on rising sck, shift on falling
      if (!sck_q)
        miso_q <= miso_i;
      else
        shift_q <= {shift_q[62:0], miso_q};
    end
  end

  assign sck_o  = sck_q;
  assign mosi_o = (sh_state == spi_core_pkg::SH_SHIFT) & shift_q[63];
  assign ss_o   = ~ss_q;
  assign irq_o  = irq_q;

endmodule

/* rtl/spi_flash_bridge.sv */
`timescale 1ns/1ps

module spi_flash_bridge #(
  parameter spi_bus_pkg::bus_addr_t flash_base = spi_bus_pkg::FLASH_BASE_DEF,
  parameter spi_bus_pkg::bus_addr_t flash_end  = spi_bus_pkg::FLASH_END_DEF,
  parameter spi_bus_pkg::bus_addr_t reg_base   = spi_bus_pkg::REG_BASE_DEF,
  parameter spi_bus_pkg::bus_addr_t reg_end    = spi_bus_pkg::REG_END_DEF,
  parameter int                     ss_num     = 8
) (
  input  logic                   clock,
  input  logic                   reset,
  input  spi_bus_pkg::bus_addr_t paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  spi_bus_pkg::bus_data_t pwdata_i,
  input  logic                   miso_i,
  output logic                   pready_o,
  output spi_bus_pkg::bus_data_t prdata_o,
  output logic                   pslverr_o,
  output logic                   sck_o,
  output logic [ss_num-1:0]      ss_o,
  output logic                   mosi_o,
  output logic                   irq_o
);

  // APB side to sequencer, sequencer to SPI registers
  spi_reg_if apb_req ();
  spi_reg_if reg_bus ();

  apb_window_decode #(
    .flash_base (flash_base),
    .flash_end  (flash_end),
    .reg_base   (reg_base),
    .reg_end    (reg_end)
  ) u_decode (
    .clock      (clock),
    .reset      (reset),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .pready_o   (pready_o),
    .prdata_o   (prdata_o),
    .pslverr_o  (pslverr_o),
    .req_o      (apb_req)
  );

  xip_read_seq u_seq (
    .clock (clock),
    .reset (reset),
    .req_i (apb_req),
    .reg_o (reg_bus)
  );

  spi_shift_regs #(
    .ss_num (ss_num)
  ) u_regs (
    .clock  (clock),
    .reset  (reset),
    .miso_i (miso_i),
    .bus_i  (reg_bus),
    .sck_o  (sck_o),
    .ss_o   (ss_o),
    .mosi_o (mosi_o),
    .irq_o  (irq_o)
  );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int reset_cycles = 8
) (
  output logic clock_o,
  output logic reset_o
);

  // 4 ns period
  initial begin
    clock_o = 1'b0;
    forever #2 clock_o = ~clock_o;
  end

  // Release just after a rising edge
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles) @(posedge clock_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

/* verification/spi_flash_bridge_assert.sv */
`timescale 1ns/1ps

module spi_flash_bridge_assert #(
  parameter int                     ss_num     = 8,
  parameter spi_bus_pkg::bus_addr_t flash_base = spi_bus_pkg::FLASH_BASE_DEF,
  parameter spi_bus_pkg::bus_addr_t flash_end  = spi_bus_pkg::FLASH_END_DEF,
  parameter spi_bus_pkg::bus_addr_t reg_base   = spi_bus_pkg::REG_BASE_DEF,
  parameter spi_bus_pkg::bus_addr_t reg_end    = spi_bus_pkg::REG_END_DEF
) (
  input logic                   clock,
  input logic                   reset,
  input spi_bus_pkg::bus_addr_t paddr_i,
  input logic                   psel_i,
  input logic                   penable_i,
  input logic                   pwrite_i,
  input logic                   pready_i,
  input logic                   pslverr_i,
  input logic                   sck_i,
  input logic [ss_num-1:0]      ss_i
);

  // Failure count of each property
  int unsigned err_ready = 0;
  int unsigned err_ss = 0;
  int unsigned err_sck = 0;
  int unsigned err_slverr = 0;
  int unsigned fail_count;
  logic        in_reg;
  logic        flash_rd;

  assign fail_count = err_ready + err_ss + err_sck + err_slverr;

  // Address windows as seen on the APB pins
  assign in_reg   = (paddr_i >= reg_base) && (paddr_i <= reg_end);
  assign flash_rd = (paddr_i >= flash_base) && (paddr_i <= flash_end) && !pwrite_i;

  // pready only inside an APB access phase
  a_ready_in_access: assert property (@(posedge clock) disable iff (reset)
    pready_i |-> (psel_i && penable_i))
    else begin
      $error("pready high outside an access phase");
      err_ready++;
    end

  // At most one slave selected
  a_single_ss: assert property (@(posedge clock) disable iff (reset)
    $onehot0(~ss_i))
    else begin
      $error("more than one slave select low");
      err_ss++;
    end

  // No clock without a selected slave
  a_sck_idle: assert property (@(posedge clock) disable iff (reset)
    (&ss_i) |-> !sck_i)
    else begin
      $error("sck high with no slave selected");
      err_sck++;
    end

  // pslverr only together with pready
  // Flash reads get no pslverr and accesses outside both windows always get it
  a_slverr_with_ready: assert property (@(posedge clock) disable iff (reset)
    (pslverr_i || pready_i) |-> (pready_i && (in_reg || (pslverr_i == !flash_rd))))
    else begin
      $error("pslverr does not match the address window of the access");
      err_slverr++;
    end

endmodule

bind spi_flash_bridge spi_flash_bridge_assert #(
  .ss_num     (ss_num),
  .flash_base (flash_base),
  .flash_end  (flash_end),
  .reg_base   (reg_base),
  .reg_end    (reg_end)
) u_assert (
  .clock     (clock),
  .reset     (reset),
  .paddr_i   (paddr_i),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pwrite_i  (pwrite_i),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o),
  .sck_i     (sck_o),
  .ss_i      (ss_o)
);

/* verification/spi_flash_bridge_tb.sv */
`timescale 1ns/1ps

module spi_flash_bridge_tb;

  localparam int          SS_NUM      = 8;
  localparam int          CYCLE_LIMIT = 20000;
  localparam logic [31:0] RAND_SEED   = 32'h1571_fa52;
  // Flash content is its address scrambled with this key
  localparam logic [31:0] XOR_KEY     = 32'hA5A5_5A5A;
  // Model answer while command and address go out
  localparam logic [31:0] ECHO_WORD   = 32'h96C3_5A0F;
  localparam logic [31:0] REG_BASE    = spi_bus_pkg::REG_BASE_DEF;
  localparam logic [31:0] CTRL_GO     = 32'h1 << spi_core_pkg::CTRL_GO_BIT;
  localparam logic [31:0] CTRL_IE     = 32'h1 << spi_core_pkg::CTRL_IE_BIT;

  logic              clock;
  logic              reset;
  logic [31:0]       paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic              miso = 1'b0;
  logic              pready;
  logic [31:0]       prdata;
  logic              pslverr;
  logic              sck_o;
  logic [SS_NUM-1:0] ss_o;
  logic              mosi_o;
  logic              irq_o;

  // Flash model state
  logic              sck_prev = 1'b0;
  logic              miso_next = 1'b0;
  int                bit_cnt = 0;
  logic [31:0]       shift_in = '0;
  logic [31:0]       out_q = '0;
  logic [7:0]        seen_cmd = '0;
  logic [23:0]       seen_addr = '0;
  int                sck_rises = 0;
  int                ss_low_cycles = 0;

  // Bookkeeping
  string             cur_test;
  int                errors = 0;
  int                tests_run = 0;
  int                tests_failed = 0;
  int                cycle_count = 0;
  int                total;

  tb_clock_gen u_clock_gen (
    .clock_o (clock),
    .reset_o (reset)
  );

  spi_flash_bridge #(
    .ss_num (SS_NUM)
  ) u_dut (
    .clock     (clock),
    .reset     (reset),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .miso_i    (miso),
    .pready_o  (pready),
    .prdata_o  (prdata),
    .pslverr_o (pslverr),
    .sck_o     (sck_o),
    .ss_o      (ss_o),
    .mosi_o    (mosi_o),
    .irq_o     (irq_o)
  );

  // Flash model on ss[0], sampled mid-cycle where pins are settled
  always @(negedge clock) begin
    if (ss_o != {SS_NUM{1'b1}})
      ss_low_cycles++;
    if (sck_o && !sck_prev)
      sck_rises++;
    if (ss_o[0]) begin
      bit_cnt   = 0;
      shift_in  = '0;
      out_q     = ECHO_WORD;
      miso_next = ECHO_WORD[31];
    end else if (sck_o && !sck_prev) begin
      // Command and address come in on the first 32 rises
      if (bit_cnt < 32)
        shift_in = {shift_in[30:0], mosi_o};
      bit_cnt++;
    end else if (!sck_o && sck_prev) begin
      if (bit_cnt == 32) begin
        seen_cmd  = shift_in[31:24];
        seen_addr = shift_in[23:0];
        out_q     = {8'h00, shift_in[23:0]} ^ XOR_KEY;
      end else begin
        out_q = out_q << 1;
      end
      miso_next = out_q[31];
    end
    sck_prev = sck_o;
  end

  // Model output moves just after the rising clock edge
  always @(posedge clock) begin
    #1;
    miso = miso_next;
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic compare_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s: %s expected %h, actual %h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic confirm(input bit ok, input string what);
    assert (ok) else begin
      $display("%s: %s", cur_test, what);
      errors++;
    end
  endtask

  // One APB transfer, cycles counted from penable to pready
  task automatic apb_xfer(input logic [31:0] addr, input logic write,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err, output int cycles);
    @(posedge clock);
    #1;
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clock);
    #1;
    penable = 1'b1;
    cycles  = 0;
    do begin
      @(posedge clock);
      cycles++;
      @(negedge clock);
    end while (!pready);
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] off, input logic [31:0] data);
    logic [31:0] unused_rd;
    logic        err;
    int          cycles;
    apb_xfer(REG_BASE + 32'(off), 1'b1, data, unused_rd, err, cycles);
    confirm(!err, "register write answered with pslverr");
    compare_word("register write cycles", 32'd4, cycles);
  endtask

  task automatic read_reg(input logic [4:0] off, output logic [31:0] data);
    logic err;
    int   cycles;
    apb_xfer(REG_BASE + 32'(off), 1'b0, 32'h0, data, err, cycles);
    confirm(!err, "register read answered with pslverr");
    compare_word("register read cycles", 32'd4, cycles);
  endtask

  // Poll until GO_BUSY drops
  task automatic wait_not_busy();
    logic [31:0] ctrl;
    do begin
      read_reg(spi_bus_pkg::OFF_CTRL, ctrl);
    end while (ctrl[spi_core_pkg::CTRL_GO_BIT]);
  endtask

  task automatic finish_test(input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("%s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("%s: %0d error(s)", cur_test, errors - errs_before);
    end
  endtask

  task automatic reg_readback();
    logic [31:0] div_val;
    logic [31:0] rd;
    int          start;
    cur_test = "reg_readback";
    start    = errors;
    div_val  = $urandom & 32'h0000_FFFF;
    write_reg(spi_bus_pkg::OFF_DIVIDER, div_val);
    write_reg(spi_bus_pkg::OFF_SS, 32'h4);
    read_reg(spi_bus_pkg::OFF_DIVIDER, rd);
    compare_word("DIVIDER", div_val, rd);
    read_reg(spi_bus_pkg::OFF_SS, rd);
    compare_word("SS", 32'h4, rd);
    confirm(ss_o == 8'hFB, "ss pins do not follow the SS register");
    write_reg(spi_bus_pkg::OFF_SS, 32'h0);
    finish_test(start);
  endtask

  task automatic manual_transfer();
    logic [31:0] rd;
    int          start;
    cur_test = "manual_transfer";
    start    = errors;
    write_reg(spi_bus_pkg::OFF_DIVIDER, 32'd2);
    write_reg(spi_bus_pkg::OFF_SS, 32'd1);
    // TX byte sits in the top bits of the shift data
    write_reg(spi_bus_pkg::OFF_TX, 32'hA700_0000);
    write_reg(spi_bus_pkg::OFF_CTRL, CTRL_GO | 32'd8);
    wait_not_busy();
    compare_word("mosi byte", 32'hA7, {24'h0, shift_in[7:0]});
    compare_word("bits clocked", 32'd8, bit_cnt);
    read_reg(spi_bus_pkg::OFF_RX, rd);
    compare_word("RX byte", {24'h0, ECHO_WORD[31:24]}, {24'h0, rd[7:0]});
    write_reg(spi_bus_pkg::OFF_SS, 32'h0);
    finish_test(start);
  endtask

  task automatic flash_reads();
    logic [31:0] addr;
    logic [31:0] rd;
    logic        err;
    int          cycles;
    int          start;
    cur_test = "flash_reads";
    start    = errors;
    repeat (3) begin
      addr = 32'h3000_0000 | ($urandom & 32'h0FFF_FFFC);
      apb_xfer(addr, 1'b0, 32'h0, rd, err, cycles);
      confirm(!err, "flash read answered with pslverr");
      compare_word("flash word", {8'h00, addr[23:0]} ^ XOR_KEY, rd);
      compare_word("command byte", 32'h03, {24'h0, seen_cmd});
      compare_word("flash address", {8'h00, addr[23:0]}, {8'h00, seen_addr});
      confirm(&ss_o, "slave select still low after the flash read");
    end
    finish_test(start);
  endtask

  task automatic bad_accesses();
    logic [31:0] rd;
    logic        err;
    int          cycles;
    int          rises_before;
    int          low_before;
    int          start;
    cur_test     = "bad_accesses";
    start        = errors;
    rises_before = sck_rises;
    low_before   = ss_low_cycles;
    apb_xfer(32'h2000_0040, 1'b0, 32'h0, rd, err, cycles);
    confirm(err, "read outside both windows was not rejected");
    compare_word("error response cycles", 32'd3, cycles);
    apb_xfer(32'h3000_0100, 1'b1, 32'hDEAD_BEEF, rd, err, cycles);
    confirm(err, "write into the flash window was not rejected");
    compare_word("error response cycles", 32'd3, cycles);
    confirm(sck_rises == rises_before && ss_low_cycles == low_before,
            "SPI pins moved during a rejected access");
    finish_test(start);
  endtask

  task automatic irq_on_done();
    logic [31:0] rd;
    int          waited;
    int          start;
    cur_test = "irq_on_done";
    start    = errors;
    write_reg(spi_bus_pkg::OFF_DIVIDER, 32'd1);
    write_reg(spi_bus_pkg::OFF_SS, 32'd1);
    write_reg(spi_bus_pkg::OFF_TX, 32'h5C00_0000);
    write_reg(spi_bus_pkg::OFF_CTRL, CTRL_IE | CTRL_GO | 32'd8);
    confirm(!irq_o, "irq high before the transfer ended");
    waited = 0;
    while (!irq_o && waited < 1000) begin
      @(negedge clock);
      waited++;
    end
    confirm(irq_o, "irq never rose after the transfer");
    read_reg(spi_bus_pkg::OFF_CTRL, rd);
    confirm(!rd[spi_core_pkg::CTRL_GO_BIT], "GO_BUSY still set while irq is high");
    // Any CTRL write drops the interrupt
    write_reg(spi_bus_pkg::OFF_CTRL, 32'h0);
    confirm(!irq_o, "irq still high after a CTRL write");
    write_reg(spi_bus_pkg::OFF_SS, 32'h0);
    finish_test(start);
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    @(negedge reset);
    reg_readback();
    manual_transfer();
    flash_reads();
    bad_accesses();
    irq_on_done();
    total = errors + int'(u_dut.u_assert.fail_count);
    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, u_dut.u_assert.fail_count);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* sim.f */
rtl/spi_bus_pkg.sv
rtl/spi_core_pkg.sv
rtl/spi_reg_if.sv
rtl/apb_window_decode.sv
rtl/xip_read_seq.sv
rtl/spi_shift_regs.sv
rtl/spi_flash_bridge.sv
verification/tb_clock_gen.sv
verification/spi_flash_bridge_assert.sv
verification/spi_flash_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run of the APB SPI flash bridge testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module spi_flash_bridge_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

# Keep running past assertion errors so the testbench reaches its summary
output=$(./obj_dir/Vspi_flash_bridge_tb +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qxF "Done: no errors"; then
  exit 0
fi
exit 1
